/* hdl/cpu_pkg.sv */
// CPU shared definitions

package cpu_pkg;

	localparam int data_w = 8;	// Data bus and register width
	localparam int addr_w = 16;	// Address bus width

	// Status bit positions, 6502 layout
	localparam int flag_c = 0;	// Carry
	localparam int flag_z = 1;	// Zero
	localparam int flag_v = 6;	// Overflow
	localparam int flag_n = 7;	// Negative

	typedef enum logic [2:0] {
		alu_pass,	// Operand through, used by transfers
		alu_adc,
		alu_sbc,
		alu_and,
		alu_ora,	// Also loads, with a zero operand
		alu_eor,
		alu_inc,
		alu_dec
	} alu_op_t;

	typedef enum logic [1:0] {
		mode_implied,
		mode_immediate,
		mode_absolute,
		mode_relative
	} addr_mode_t;

	typedef enum logic [1:0] {
		reg_none,
		reg_a,
		reg_x,
		reg_y
	} reg_sel_t;

	// Opcode byte, whole or split into aaa bbb cc
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] aaa;	// Operation within group
			logic [2:0] bbb;	// Addressing mode
			logic [1:0] cc;	// Group
		} fields;
	} opcode_t;

endpackage

/* hdl/cpu_alu.sv */
// Arithmetic and logic unit

`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
	input  alu_op_t           alu_op,
	input  logic [data_w-1:0] operand,	// Register side
	input  logic [data_w-1:0] rdata,	// Memory side
	input  logic              carry_in,
	output logic [data_w-1:0] result,
	output logic [data_w-1:0] flags_out
);

	logic [data_w-1:0] addend;
	logic [data_w:0]   sum;

	always_comb begin
		// SBC is A + ~M + C, borrow shows as carry clear
		addend = (alu_op == alu_sbc) ? ~rdata : rdata;
		sum = {1'b0, operand} + {1'b0, addend} + {{data_w{1'b0}}, carry_in};
		result = operand;
		flags_out = '0;
		flags_out[flag_c] = carry_in;	// Untouched unless adding
		case (alu_op)
			alu_adc, alu_sbc: begin
				result = sum[data_w-1:0];
				flags_out[flag_c] = sum[data_w];
				// Like signs in, other sign out
				flags_out[flag_v] = (operand[data_w-1] == addend[data_w-1])
					&& (sum[data_w-1] != operand[data_w-1]);
			end
			alu_and: result = operand & rdata;
			alu_ora: result = operand | rdata;
			alu_eor: result = operand ^ rdata;
			alu_inc: result = operand + 1'b1;
			alu_dec: result = operand - 1'b1;
			default: result = operand;
		endcase
		flags_out[flag_n] = result[data_w-1];
		flags_out[flag_z] = (result == '0);
	end

endmodule

/* hdl/cpu_regs.sv */
// Register file and status

`timescale 1ns/1ps

module cpu_regs import cpu_pkg::*; (
	input  logic              CLK,
	input  logic              rst,
	input  logic              reg_we,
	input  logic              flag_we,
	input  reg_sel_t          dst,
	input  reg_sel_t          src,
	input  logic [data_w-1:0] result,
	input  logic [data_w-1:0] flags_out,
	output logic [data_w-1:0] operand,
	output logic [data_w-1:0] store_data,
	output logic [data_w-1:0] flags
);

	logic [data_w-1:0] acc, idx_x, idx_y;

	always_ff @(posedge CLK) begin
		if (rst) begin
			acc <= '0;
			idx_x <= '0;
			idx_y <= '0;
			flags <= '0;
		end else begin
			if (reg_we) begin
				case (dst)
					reg_a: acc <= result;
					reg_x: idx_x <= result;
					reg_y: idx_y <= result;
					default: ;	// CLC SEC write no register
				endcase
			end
			if (flag_we) begin
				if (dst == reg_none) begin
					flags[flag_c] <= result[0];	// CLC gives 0, SEC gives 1
				end else begin
					flags[flag_n] <= flags_out[flag_n];
					flags[flag_z] <= flags_out[flag_z];
					if (dst == reg_a && src == reg_a) begin	// Accumulator ALU group
						flags[flag_c] <= flags_out[flag_c];
						flags[flag_v] <= flags_out[flag_v];
					end
				end
			end
		end
	end

	// Zero operand when no register, so loads pass memory through
	always_comb begin
		case (src)
			reg_a: operand = acc;
			reg_x: operand = idx_x;
			reg_y: operand = idx_y;
			default: operand = '0;
		endcase
		case (dst)
			reg_x: store_data = idx_x;
			reg_y: store_data = idx_y;
			default: store_data = acc;
		endcase
	end

endmodule

/* hdl/cpu_decode.sv */
// Opcode latch and decoder

`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
	input  logic              CLK,
	input  logic              rst,
	input  logic              op_load,
	input  logic [data_w-1:0] rdata,
	input  logic [data_w-1:0] flags,
	output alu_op_t           alu_op,
	output addr_mode_t        mode,
	output reg_sel_t          dst,	// Register loaded, or stored for a store
	output reg_sel_t          src,	// ALU operand register
	output logic              is_store,
	output logic              is_jump,
	output logic              branch_taken,
	output logic              illegal
);

	opcode_t op;
	logic    is_branch;
	logic    cond_flag;

	always_ff @(posedge CLK) begin
		if (rst)
			op.raw <= '0;
		else if (op_load)
			op.raw <= rdata;
	end

	always_comb begin
		alu_op = alu_pass;
		mode = mode_implied;
		dst = reg_none;
		src = reg_none;
		is_store = 1'b0;
		is_jump = 1'b0;
		is_branch = 1'b0;
		illegal = 1'b0;
		case (op.raw)
			8'haa: begin dst = reg_x; src = reg_a; end	// TAX
			8'h8a: begin dst = reg_a; src = reg_x; end	// TXA
			8'he8: begin alu_op = alu_inc; dst = reg_x; src = reg_x; end	// INX
			8'hca: begin alu_op = alu_dec; dst = reg_x; src = reg_x; end	// DEX
			8'hc8: begin alu_op = alu_inc; dst = reg_y; src = reg_y; end	// INY
			8'h88: begin alu_op = alu_dec; dst = reg_y; src = reg_y; end	// DEY
			8'h18: alu_op = alu_pass;	// CLC, zero through
			8'h38: alu_op = alu_inc;	// SEC, zero plus one
			8'h90, 8'hb0, 8'hd0, 8'hf0: begin
				mode = mode_relative;
				is_branch = 1'b1;
			end
			8'h4c: begin mode = mode_absolute; is_jump = 1'b1; end
			default: begin
				// Group decode on the field view
				if (op.fields.cc == 2'b01 && op.fields.bbb[2:1] == 2'b01) begin
					mode = op.fields.bbb[0] ? mode_absolute : mode_immediate;
					dst = reg_a;
					src = reg_a;
					case (op.fields.aaa)
						3'b000: alu_op = alu_ora;
						3'b001: alu_op = alu_and;
						3'b010: alu_op = alu_eor;
						3'b011: alu_op = alu_adc;
						3'b100: begin	// STA, no immediate form
							is_store = 1'b1;
							illegal = !op.fields.bbb[0];
						end
						3'b101: begin alu_op = alu_ora; src = reg_none; end	// LDA
						3'b111: alu_op = alu_sbc;
						default: illegal = 1'b1;	// CMP
					endcase
				end else if (!op.fields.cc[0] && op.fields.aaa[2:1] == 2'b10
						&& (op.fields.bbb == 3'b000 || op.fields.bbb == 3'b011)) begin
					// LDX LDY STX STY
					mode = op.fields.bbb[0] ? mode_absolute : mode_immediate;
					dst = op.fields.cc[1] ? reg_x : reg_y;
					is_store = !op.fields.aaa[0];
					alu_op = alu_ora;	// Zero operand, memory byte through
					illegal = is_store && !op.fields.bbb[0];
				end else begin
					illegal = 1'b1;
				end
			end
		endcase
	end

	// Bit 6 picks Z over C, bit 5 the wanted value
	assign cond_flag = op.raw[6] ? flags[flag_z] : flags[flag_c];
	assign branch_taken = is_branch && (cond_flag == op.raw[5]);

endmodule

/* hdl/cpu_bus.sv */
// Program counter and Wishbone master

`timescale 1ns/1ps

module cpu_bus import cpu_pkg::*; #(
	parameter logic [addr_w-1:0] reset_vector = 16'hfffc
) (
	input  logic              CLK,
	input  logic              rst,
	input  logic              bus_req,
	input  logic              bus_we,
	input  logic              addr_src,
	input  logic              pc_inc,
	input  logic              pc_load_vec,
	input  logic              pc_load_abs,
	input  logic              pc_add_rel,
	input  logic              adr_lo_we,
	input  logic              adr_hi_we,
	input  logic [data_w-1:0] store_data,
	input  logic [data_w-1:0] wb_dat_r,
	input  logic              wb_ack,
	output logic [data_w-1:0] rdata,
	output logic              bus_done,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output logic [addr_w-1:0] wb_adr,
	output logic [data_w-1:0] wb_dat_w
);

	logic [addr_w-1:0] pc;
	logic [addr_w-1:0] adr;	// Operand address
	logic [addr_w-1:0] rel;	// Sign-extended branch offset

	assign rel = {{(addr_w-data_w){rdata[data_w-1]}}, rdata};

	// ----------------------------------------------------------------------
	// Program counter and operand address
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (rst)
			pc <= reset_vector;	// Vector bytes are read through pc
		else if (pc_load_vec || pc_load_abs)
			pc <= {rdata, adr[data_w-1:0]};	// High byte straight off the bus
		else if (pc_add_rel)
			pc <= pc + 1'b1 + rel;	// Offset counts from the next opcode
		else if (pc_inc)
			pc <= pc + 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (adr_lo_we)
			adr[data_w-1:0] <= rdata;
		if (adr_hi_we)
			adr[addr_w-1:data_w] <= rdata;
	end

	// ----------------------------------------------------------------------
	// Wishbone classic, one transfer per request
	// ----------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_cyc <= 1'b0;
			wb_we <= 1'b0;
			bus_done <= 1'b0;
		end else begin
			bus_done <= 1'b0;
			if (bus_req) begin
				wb_cyc <= 1'b1;
				wb_we <= bus_we;
			end else if (wb_cyc && wb_ack) begin
				wb_cyc <= 1'b0;	// Drop after the acknowledge edge
				wb_we <= 1'b0;
				bus_done <= 1'b1;
			end
		end
	end

	// Address and write data held for the whole cycle
	always_ff @(posedge CLK) begin
		if (bus_req) begin
			wb_adr <= addr_src ? adr : pc;
			wb_dat_w <= store_data;
		end
		if (wb_cyc && wb_ack && !wb_we)
			rdata <= wb_dat_r;	// Valid together with bus_done
	end

	assign wb_stb = wb_cyc;

endmodule

/* hdl/cpu_control.sv */
// Instruction sequencer

`timescale 1ns/1ps

module cpu_control import cpu_pkg::*; #(
	parameter bit trap_illegal = 1'b1
) (
	input  logic       CLK,
	input  logic       rst,
	input  logic       bus_done,
	input  addr_mode_t mode,
	input  logic       branch_taken,
	input  logic       illegal,
	input  logic       is_store,
	input  logic       is_jump,
	output logic       bus_req,
	output logic       bus_we,
	output logic       addr_src,	// 0 program counter, 1 operand address
	output logic       pc_inc,
	output logic       pc_load_vec,
	output logic       pc_load_abs,
	output logic       pc_add_rel,
	output logic       adr_lo_we,
	output logic       adr_hi_we,
	output logic       op_load,
	output logic       reg_we,
	output logic       flag_we,
	output logic       sync,
	output logic       trap
);

	// ----------------------------------------------------------------------
	// States
	// ----------------------------------------------------------------------
	localparam logic [2:0] st_vec_lo   = 3'd0;	// Reset vector, low byte
	localparam logic [2:0] st_vec_hi   = 3'd1;
	localparam logic [2:0] st_fetch    = 3'd2;
	localparam logic [2:0] st_oper_lo  = 3'd3;	// Immediate, offset or address low
	localparam logic [2:0] st_oper_hi  = 3'd4;
	localparam logic [2:0] st_data     = 3'd5;	// Absolute read or write
	localparam logic [2:0] st_execute  = 3'd6;	// Dispatch after fetch
	localparam logic [2:0] st_trap     = 3'd7;

	logic [2:0] state, state_nx;
	logic       busy;	// Request issued, waiting for bus_done

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= st_vec_lo;
			busy <= 1'b0;
		end else begin
			state <= state_nx;
			if (bus_req)
				busy <= 1'b1;
			else if (bus_done)
				busy <= 1'b0;
		end
	end

	always_comb begin
		state_nx = state;
		bus_req = 1'b0;
		pc_inc = 1'b0;
		pc_load_vec = 1'b0;
		pc_load_abs = 1'b0;
		pc_add_rel = 1'b0;
		adr_lo_we = 1'b0;
		adr_hi_we = 1'b0;
		op_load = 1'b0;
		reg_we = 1'b0;
		flag_we = 1'b0;
		case (state)
			st_vec_lo: begin
				bus_req = !busy;
				if (bus_done) begin
					adr_lo_we = 1'b1;	// Park vector low byte
					pc_inc = 1'b1;
					state_nx = st_vec_hi;
				end
			end
			st_vec_hi: begin
				bus_req = !busy;
				if (bus_done) begin
					pc_load_vec = 1'b1;
					state_nx = st_fetch;
				end
			end
			st_fetch: begin
				bus_req = !busy;
				if (bus_done) begin
					op_load = 1'b1;
					pc_inc = 1'b1;
					state_nx = st_execute;
				end
			end
			st_execute: begin
				// Opcode valid from here on
				if (illegal) begin
					state_nx = trap_illegal ? st_trap : st_fetch;	// Else one-byte no-op
				end else if (mode == mode_implied) begin
					reg_we = 1'b1;
					flag_we = 1'b1;
					state_nx = st_fetch;
				end else begin
					bus_req = 1'b1;	// First operand byte, no extra cycle
					state_nx = st_oper_lo;
				end
			end
			st_oper_lo: begin
				if (bus_done) begin
					pc_inc = 1'b1;
					case (mode)
						mode_immediate: begin
							reg_we = 1'b1;
							flag_we = 1'b1;
							state_nx = st_fetch;
						end
						mode_relative: begin
							pc_add_rel = branch_taken;
							state_nx = st_fetch;
						end
						default: begin
							adr_lo_we = 1'b1;
							state_nx = st_oper_hi;
						end
					endcase
				end
			end
			st_oper_hi: begin
				bus_req = !busy;
				if (bus_done) begin
					pc_inc = !is_jump;
					pc_load_abs = is_jump;
					adr_hi_we = !is_jump;
					state_nx = is_jump ? st_fetch : st_data;
				end
			end
			st_data: begin
				bus_req = !busy;
				if (bus_done) begin
					reg_we = !is_store;
					flag_we = !is_store;
					state_nx = st_fetch;
				end
			end
			default: ;	// Trap holds until reset
		endcase
	end

	assign bus_we = (state == st_data) && is_store;
	assign addr_src = (state == st_data);
	assign sync = (state == st_fetch);
	assign trap = (state == st_trap);

endmodule

/* hdl/cpu_top.sv */
// CPU core top level

`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter logic [addr_w-1:0] reset_vector = 16'hfffc,
	parameter bit trap_illegal = 1'b1
) (
	input  logic              CLK,
	input  logic              rst,
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic              wb_we,
	output logic [addr_w-1:0] wb_adr,
	output logic [data_w-1:0] wb_dat_w,
	input  logic [data_w-1:0] wb_dat_r,
	input  logic              wb_ack,
	output logic              sync,
	output logic              trap
);

	// Control to bus
	logic bus_req, bus_we, addr_src, bus_done;
	logic pc_inc, pc_load_vec, pc_load_abs, pc_add_rel;
	logic adr_lo_we, adr_hi_we;
	// Control to decode and registers
	logic op_load, reg_we, flag_we;
	// Decode results
	alu_op_t    alu_op;
	addr_mode_t mode;
	reg_sel_t   dst, src;
	logic       is_store, is_jump, branch_taken, illegal;
	// Datapath
	logic [data_w-1:0] rdata, result, flags_out, operand, store_data, flags;

	cpu_control #(.trap_illegal(trap_illegal)) u_control (
		.CLK(CLK), .rst(rst), .bus_done(bus_done), .mode(mode),
		.branch_taken(branch_taken), .illegal(illegal), .is_store(is_store),
		.is_jump(is_jump), .bus_req(bus_req), .bus_we(bus_we), .addr_src(addr_src),
		.pc_inc(pc_inc), .pc_load_vec(pc_load_vec), .pc_load_abs(pc_load_abs),
		.pc_add_rel(pc_add_rel), .adr_lo_we(adr_lo_we), .adr_hi_we(adr_hi_we),
		.op_load(op_load), .reg_we(reg_we), .flag_we(flag_we), .sync(sync), .trap(trap)
	);

	cpu_decode u_decode (
		.CLK(CLK), .rst(rst), .op_load(op_load), .rdata(rdata), .flags(flags),
		.alu_op(alu_op), .mode(mode), .dst(dst), .src(src), .is_store(is_store),
		.is_jump(is_jump), .branch_taken(branch_taken), .illegal(illegal)
	);

	cpu_alu u_alu (
		.alu_op(alu_op), .operand(operand), .rdata(rdata), .carry_in(flags[flag_c]),
		.result(result), .flags_out(flags_out)
	);

	cpu_regs u_regs (
		.CLK(CLK), .rst(rst), .reg_we(reg_we), .flag_we(flag_we), .dst(dst), .src(src),
		.result(result), .flags_out(flags_out), .operand(operand),
		.store_data(store_data), .flags(flags)
	);

	cpu_bus #(.reset_vector(reset_vector)) u_bus (
		.CLK(CLK), .rst(rst), .bus_req(bus_req), .bus_we(bus_we), .addr_src(addr_src),
		.pc_inc(pc_inc), .pc_load_vec(pc_load_vec), .pc_load_abs(pc_load_abs),
		.pc_add_rel(pc_add_rel), .adr_lo_we(adr_lo_we), .adr_hi_we(adr_hi_we),
		.store_data(store_data), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .rdata(rdata),
		.bus_done(bus_done), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w)
	);

endmodule

/* dv/tb_assert.sv */
// Wishbone protocol assertions

`timescale 1ns/1ps

module tb_assert import cpu_pkg::*; (
	input logic              CLK,
	input logic              rst,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic              wb_we,
	input logic [addr_w-1:0] wb_adr,
	input logic [data_w-1:0] wb_dat_w,
	input logic              wb_ack,
	input logic              trap
);

	int fail_count = 0;	// Failed assertions so far

	// Strobe and cycle fall on the edge after ack
	drop_after_ack: assert property (@(posedge CLK) disable iff (rst)
		wb_stb && wb_ack |=> !wb_stb && !wb_cyc)
		else begin
			fail_count++;
			$error("Cycle still open after ack");
		end

	// Master holds the request until ack
	held_request: assert property (@(posedge CLK) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
			&& $stable(wb_dat_w))
		else begin
			fail_count++;
			$error("Request changed before ack");
		end

	trap_sticky: assert property (@(posedge CLK) disable iff (rst) trap |=> trap)
		else begin
			fail_count++;
			$error("trap fell without reset");
		end

	no_cyc_in_reset: assert property (@(posedge CLK) rst |=> !wb_cyc)
		else begin
			fail_count++;
			$error("wb_cyc high during reset");
		end

endmodule

bind cpu_top tb_assert u_assert (
	.CLK(CLK), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
	.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .trap(trap)
);

/* dv/tb_top.sv */
// CPU core testbench

`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

	localparam logic [addr_w-1:0] exp_base = 16'he000;	// Expected write table

	logic              CLK;
	logic              rst = 1'b1;
	logic              wb_cyc, wb_stb, wb_we;
	logic [addr_w-1:0] wb_adr;
	logic [data_w-1:0] wb_dat_w;
	logic [data_w-1:0] wb_dat_r = '0;
	logic              wb_ack = 1'b0;
	logic              sync, trap;

	logic [data_w-1:0] mem [0:(1<<addr_w)-1];	// Whole 64 KiB space
	logic [addr_w-1:0] exp_adr[$];
	logic [data_w-1:0] exp_dat[$];
	logic [addr_w-1:0] vector, trap_adr;
	logic [addr_w-1:0] last_fetch = '0;
	logic [31:0]       lfsr = 32'hf31f_033f;
	logic [1:0]        wait_left = '0;	// Ack delay of the open transfer
	logic              in_xfer = 1'b0;
	int                xfer_count = 0;
	int                write_count = 0;
	int                check_count = 0;
	int                err_count = 0;
	int                cycle_count = 0;
	int                cycle_limit = 0;	// Zero until the image is loaded

	cpu_top #(.reset_vector(16'hfffc), .trap_illegal(1'b1)) uut (
		.CLK(CLK), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.sync(sync), .trap(trap)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;	// 100 ns period
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic print_counts();
		$display("Checks %0d, errors %0d, writes %0d of %0d", check_count, err_count,
			write_count, exp_adr.size());
	endtask

	// Triples until address FFFF, trap address right after
	task automatic load_expected();
		int a;
		logic [addr_w-1:0] w;
		a = exp_base;
		w = {mem[a+1], mem[a]};
		while (w != 16'hffff && a < 16'hfff0) begin
			exp_adr.push_back(w);
			exp_dat.push_back(mem[a+2]);
			a = a + 3;
			w = {mem[a+1], mem[a]};
		end
		trap_adr = {mem[a+3], mem[a+2]};
	endtask

	// ----------------------------------------------------------------------
	// Memory model, driven on the falling edge
	// ----------------------------------------------------------------------
	task automatic start_transfer();
		case (xfer_count)
			0: check_value("wb_adr", wb_adr, 16'hfffc);	// Vector low
			1: check_value("wb_adr", wb_adr, 16'hfffd);
			2: begin
				check_value("wb_adr", wb_adr, vector);	// First opcode
				check_value("sync", sync, 1'b1);
			end
			default: ;
		endcase
		if (xfer_count < 2) begin
			check_value("wb_we", wb_we, 1'b0);
			check_value("sync", sync, 1'b0);
		end
		if (sync)
			last_fetch = wb_adr;
		xfer_count++;
	endtask

	task automatic finish_transfer();
		if (wb_we) begin
			if (write_count < exp_adr.size()) begin
				check_value("wb_adr", wb_adr, exp_adr[write_count]);
				check_value("wb_dat_w", wb_dat_w, exp_dat[write_count]);
			end else begin
				err_count++;
				$display("Unexpected write of %h to %h after the last expected one",
					wb_dat_w, wb_adr);
			end
			mem[wb_adr] = wb_dat_w;
			write_count++;
		end else begin
			wb_dat_r <= mem[wb_adr];
		end
		wb_ack <= 1'b1;
	endtask

	always @(negedge CLK) begin
		if (rst || !(wb_cyc && wb_stb)) begin
			wb_ack <= 1'b0;	// Cycle dropped after the ack edge
			in_xfer = 1'b0;
		end else if (!wb_ack) begin
			if (!in_xfer) begin
				in_xfer = 1'b1;
				lfsr = lfsr_next(lfsr);
				wait_left[0] = lfsr[0];
				lfsr = lfsr_next(lfsr);
				wait_left[1] = lfsr[0];
				start_transfer();
			end
			if (wait_left == 2'd0)
				finish_transfer();
			else
				wait_left = wait_left - 2'd1;	// Hold off the ack
		end
	end

	// Watchdog
	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout with no trap after %0d cycles", cycle_count);
			print_counts();
			$display("Simulation failed");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin
		for (int i = 0; i < (1 << addr_w); i++)
			mem[i] = i[15:8] ^ {i[6:0], i[7]};	// Every address bit counts
		$readmemh("dv/cpu_patterns.hex", mem);
		load_expected();
		vector = {mem[16'hfffd], mem[16'hfffc]};
		cycle_limit = 8 * (int'(trap_adr) - int'(vector) + 1) * 4;
		repeat (4) @(negedge CLK);
		rst = 1'b0;
		while (!trap)
			@(negedge CLK);
		check_value("wb_cyc", wb_cyc, 1'b0);	// Bus idle at trap
		check_value("wb_adr (last fetch)", last_fetch, trap_adr);
		repeat (4) @(negedge CLK);
		check_value("wb_cyc", wb_cyc, 1'b0);
		check_value("trap", trap, 1'b1);
		check_value("write_count", write_count, exp_adr.size());
		if (uut.u_assert.fail_count != 0) begin
			$display("%0d Wishbone assertion failures", uut.u_assert.fail_count);
			err_count += uut.u_assert.fail_count;
		end
		print_counts();
		if (err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* dv/cpu_patterns.hex */
// Bytes in hex and @ sets the load address
// Table at E000 holds address low, address high and data per write; FFFF ends it
// Program at 0200, ends on the unsupported opcode 02 at 0277
@0200
A9 5A 8D 00 03 AA E8 8E 01 03 A0 80 88 8C 02 03
AD 40 03 18 69 C9 8D 03 03 6D 41 03 8D 04 03 38
E9 0F 8D 05 03 ED 40 03 8D 06 03 29 F0 09 0F 4D
42 03 8D 07 03 B0 02 A2 EE 90 02 A2 11 8E 08 03
A9 00 F0 03 8E 09 03 D0 03 A0 22 8C 09 03 A2 03
CA D0 FD 8E 0A 03 E8 8A 8D 0B 03 4C 62 02 8D 0C
03 02 A9 FF 69 01 8D 0C 03 18 B0 03 90 03 8C 0E
03 C8 F0 03 8C 0D 03 02
// Operands of the absolute loads and ALU ops
@0340
37 C9 0F
// Expected writes, two per line, then terminator and trap address
@E000
00 03 5A 01 03 5B
02 03 7F 03 03 00
04 03 CA 05 03 BB
06 03 84 07 03 80
08 03 11 09 03 22
0A 03 00 0B 03 01
0C 03 01 0D 03 23
FF FF 77 02
// Reset vector
@FFFC
00 02

/* tb.f */
hdl/cpu_pkg.sv
hdl/cpu_alu.sv
hdl/cpu_regs.sv
hdl/cpu_decode.sv
hdl/cpu_bus.sv
hdl/cpu_control.sv
hdl/cpu_top.sv
dv/tb_assert.sv
dv/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
